// ==== hdl/z80IsaPkg.sv ====
// Instruction set definitions for the Z80 subset core
// Cycle counter sizing and per-instruction last cycle
// Opcode constants and casez group patterns
// Condition flag positions in F
// Data-port address sources and temporary word actions
package z80IsaPkg;

    // Cycle counting ----------------------------
    localparam int maxCycle = 3;
    localparam int cycleW   = $clog2(maxCycle + 1);

    typedef logic [cycleW-1:0] cycleT;

    // Last cycle index per instruction length
    localparam cycleT lastCycleOne  = cycleT'(0);
    localparam cycleT lastCycleTwo  = cycleT'(1);
    localparam cycleT lastCycleFour = cycleT'(maxCycle);

    // Opcodes ------------------------------------
    localparam logic [7:0] opNop  = 8'h00;
    localparam logic [7:0] opExAf = 8'h08;
    localparam logic [7:0] opDjnz = 8'h10;
    localparam logic [7:0] opJr   = 8'h18;

    // Group patterns, ? bits are don't care in casez
    // JR NZ/Z/NC/C, bit 4 picks the flag, bit 3 the polarity
    localparam logic [7:0] jrCc      = 8'b001??000;
    // LD rr,nn with rr in bits 5:4
    localparam logic [7:0] ldPairImm = 8'b00??0001;
    // LD (BC)/(DE),A
    localparam logic [7:0] stPairA   = 8'b000?0010;
    // LD A,(BC)/(DE)
    localparam logic [7:0] ldAPair   = 8'b000?1010;
    localparam logic [7:0] stAbsHl   = 8'h22;
    localparam logic [7:0] ldHlAbs   = 8'h2A;

    // Flag bit positions in F
    localparam int condIdxZ = 6;
    localparam int condIdxC = 0;

    // Datapath control codes ---------------------
    // Source of the data-port address
    typedef enum logic [1:0] {
        pcNext   = 2'b00,
        pairBcDe = 2'b01,
        tempInc  = 2'b10,
        codeTemp = 2'b11
    } addrSrcT;

    // Action on the temporary word
    typedef enum logic [1:0] {
        tempHold     = 2'b00,
        tempLoadLow  = 2'b01,
        tempLoadHigh = 2'b10
    } tempOpT;

endpackage

// ==== hdl/z80RegPkg.sv ====
// Architectural state definitions for the Z80 subset core
// Byte and address types, register pair select codes
// Reset values of the main set, the alternate set, PC and SP
package z80RegPkg;

    typedef logic [7:0]  byteT;
    typedef logic [15:0] addrT;
    typedef logic [1:0]  pairSelT;

    // Register pair codes as in opcode bits 5:4
    localparam pairSelT selBc = 2'b00;
    localparam pairSelT selDe = 2'b01;
    localparam pairSelT selHl = 2'b10;
    localparam pairSelT selSp = 2'b11;

    // Byte load targets reuse the same code
    // BC/DE select means A, as in LD A,(rr)
    localparam pairSelT byteL = selHl;
    localparam pairSelT byteH = selSp;

    // One full register set ----------------------
    typedef struct packed {
        byteT b;
        byteT c;
        byteT d;
        byteT e;
        byteT h;
        byteT l;
        byteT a;
        byteT f;
    } regSetT;

    // F of 0 clears Z and C
    localparam regSetT resetMain = '{b: 8'h00, c: 8'h00, d: 8'h00, e: 8'h00,
                                     h: 8'h00, l: 8'h00, a: 8'h00, f: 8'h00};

    // F' of 41h sets Z and C
    localparam regSetT resetAlt = '{b: 8'h00, c: 8'h00, d: 8'h00, e: 8'h00,
                                    h: 8'h00, l: 8'h00, a: 8'hFA, f: 8'h41};

    localparam addrT resetPc = 16'h0000;
    localparam addrT resetSp = 16'h0000;

endpackage

// ==== hdl/z80Decode.sv ====
// Instruction decode for the Z80 subset core
// Opcode latch held across the cycles of one instruction
// Cycle counter, cleared on the last cycle
// Per-cycle strobes for PC, temporary word, data port and registers
`timescale 1ns/1ns

module z80Decode (
    input  logic               clk,
    input  logic               rstN,
    input  z80RegPkg::byteT    codeData,
    input  z80RegPkg::byteT    flags,
    output logic [1:0]         pcStep,
    output logic               pcRel,
    output z80IsaPkg::tempOpT  tempOp,
    output z80IsaPkg::addrSrcT addrSrc,
    output logic               memWrite,
    output logic               writeByte,
    output logic               writePair,
    output z80RegPkg::pairSelT pairSel,
    output logic               exAf,
    output logic               decB,
    input  logic               bNonZero
);

    import z80IsaPkg::*;
    import z80RegPkg::*;

    cycleT cycle;
    cycleT lastCycle;
    byteT  opLatch;
    byteT  opcode;
    logic  condTrue;

    // Cycle 0 decodes straight from the code port
    assign opcode = (cycle == '0) ? codeData : opLatch;

    // Bit 4 picks Z or C, bit 3 the wanted value
    assign condTrue = flags[opcode[4] ? condIdxC : condIdxZ] == opcode[3];

    // Control strobes ----------------------------
    always_comb begin
        pcStep    = 2'd1;
        pcRel     = 1'b0;
        tempOp    = tempHold;
        addrSrc   = pcNext;
        memWrite  = 1'b0;
        writeByte = 1'b0;
        writePair = 1'b0;
        pairSel   = opcode[5:4];
        exAf      = 1'b0;
        decB      = 1'b0;
        lastCycle = lastCycleOne;

        casez (opcode)
            opNop: begin
                pcStep = 2'd1;
            end
            opExAf: begin
                exAf = 1'b1;
            end
            // B-1 tested before the decrement lands
            opDjnz: begin
                decB   = 1'b1;
                pcStep = 2'd2;
                pcRel  = bNonZero;
            end
            opJr: begin
                pcStep = 2'd2;
                pcRel  = 1'b1;
            end
            jrCc: begin
                pcStep = 2'd2;
                pcRel  = condTrue;
            end
            // Low byte into temp, then high byte with the pair write
            ldPairImm: begin
                lastCycle = lastCycleTwo;
                if (cycle == '0) begin
                    tempOp = tempLoadLow;
                end else begin
                    writePair = 1'b1;
                    pcStep    = 2'd2;
                end
            end
            stPairA: begin
                lastCycle = lastCycleTwo;
                if (cycle != '0) begin
                    addrSrc  = pairBcDe;
                    memWrite = 1'b1;
                    pcStep   = 2'd0;
                end
            end
            ldAPair: begin
                lastCycle = lastCycleTwo;
                if (cycle != '0) begin
                    addrSrc   = pairBcDe;
                    writeByte = 1'b1;
                    pcStep    = 2'd0;
                end
            end
            // PC parks on the high address byte until the last cycle
            stAbsHl, ldHlAbs: begin
                lastCycle = lastCycleFour;
                case (cycle)
                    2'd0: begin
                        tempOp = tempLoadLow;
                        pcStep = 2'd2;
                    end
                    2'd1: begin
                        tempOp = tempLoadHigh;
                        pcStep = 2'd0;
                    end
                    2'd2: begin
                        addrSrc   = codeTemp;
                        memWrite  = (opcode == stAbsHl);
                        writeByte = (opcode == ldHlAbs);
                        pairSel   = byteL;
                        pcStep    = 2'd0;
                    end
                    default: begin
                        addrSrc   = tempInc;
                        memWrite  = (opcode == stAbsHl);
                        writeByte = (opcode == ldHlAbs);
                        pairSel   = byteH;
                        pcStep    = 2'd1;
                    end
                endcase
            end
            // Anything else is a one-cycle NOP
            default: begin
                pcStep = 2'd1;
            end
        endcase
    end

    // Cycle counter and opcode latch ----------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            cycle <= '0;
        end else if (cycle == lastCycle) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cycle == '0) begin
            opLatch <= codeData;
        end
    end

    // Counter stays inside the latched instruction's length
    cycleInRange: assert property (@(posedge clk) disable iff (!rstN)
        cycle <= lastCycle)
        else $error("cycle index %0d out of range", cycle);

endmodule

// ==== hdl/z80Execute.sv ====
// Execute stage of the Z80 subset core
// Program counter with step and relative branch
// Temporary word for absolute addresses
// Code and data port address, write data and write strobe
`timescale 1ns/1ns

module z80Execute (
    input  logic               clk,
    input  logic               rstN,
    input  logic [1:0]         pcStep,
    input  logic               pcRel,
    input  z80IsaPkg::tempOpT  tempOp,
    input  z80IsaPkg::addrSrcT addrSrc,
    input  logic               memWrite,
    input  z80RegPkg::pairSelT pairSel,
    input  z80RegPkg::byteT    codeData,
    input  z80RegPkg::byteT    dataIn,
    input  z80RegPkg::byteT    regA,
    input  z80RegPkg::byteT    regH,
    input  z80RegPkg::byteT    regL,
    input  z80RegPkg::addrT    pairBc,
    input  z80RegPkg::addrT    pairDe,
    output z80RegPkg::addrT    codeAddr,
    output z80RegPkg::addrT    dataAddr,
    output z80RegPkg::byteT    dataOut,
    output logic               dataWrite,
    output z80RegPkg::addrT    loadWord
);

    import z80IsaPkg::*;
    import z80RegPkg::*;

    addrT pc;
    addrT tempWord;
    addrT relTarget;

    // Offset is relative to the byte after the instruction
    assign relTarget = pc + 16'd2 + {{8{dataIn[7]}}, dataIn};

    assign codeAddr  = pc;
    assign dataWrite = memWrite;

    // High byte from memory, low byte kept from the earlier cycle
    assign loadWord  = {dataIn, tempWord[7:0]};

    // Data port ----------------------------------
    always_comb begin
        case (addrSrc)
            pairBcDe: dataAddr = (pairSel == selDe) ? pairDe : pairBc;
            tempInc:  dataAddr = tempWord + 16'd1;
            codeTemp: dataAddr = {codeData, tempWord[7:0]};
            default:  dataAddr = pc + 16'd1;
        endcase
    end

    // L goes out first, H at the next address
    always_comb begin
        case (addrSrc)
            codeTemp: dataOut = regL;
            tempInc:  dataOut = regH;
            default:  dataOut = regA;
        endcase
    end

    // PC and temporary word ----------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (pcRel) begin
            pc <= relTarget;
        end else begin
            pc <= pc + {14'd0, pcStep};
        end
    end

    always_ff @(posedge clk) begin
        case (tempOp)
            tempLoadLow:  tempWord[7:0]  <= dataIn;
            tempLoadHigh: tempWord[15:8] <= codeData;
            default:      tempWord       <= tempWord;
        endcase
    end

    // Decode holds its counter at 0 while reset stays low
    noWriteInReset: assert property (@(posedge clk)
        (!rstN && $past(!rstN)) |-> !dataWrite)
        else $error("memory write strobe during reset");

endmodule

// ==== hdl/z80Result.sv ====
// Register file of the Z80 subset core
// Main set B C D E H L A F, stack pointer, alternate A' and F'
// Write-back of pair and byte loads, B decrement, EX AF,AF'
// Read-out of A, F, H, L, BC, DE and the DJNZ condition
`timescale 1ns/1ns

module z80Result (
    input  logic               clk,
    input  logic               rstN,
    input  logic               writeByte,
    input  logic               writePair,
    input  logic               exAf,
    input  logic               decB,
    input  z80RegPkg::pairSelT pairSel,
    input  z80RegPkg::addrT    loadWord,
    input  z80RegPkg::byteT    dataIn,
    output z80RegPkg::byteT    regA,
    output z80RegPkg::byteT    regH,
    output z80RegPkg::byteT    regL,
    output z80RegPkg::byteT    flags,
    output z80RegPkg::addrT    pairBc,
    output z80RegPkg::addrT    pairDe,
    output logic               bNonZero
);

    import z80RegPkg::*;

    byteT regB;
    byteT regC;
    byteT regD;
    byteT regE;
    byteT regF;
    byteT altA;
    byteT altF;
    addrT regSp;

    assign flags  = regF;
    assign pairBc = {regB, regC};
    assign pairDe = {regD, regE};

    // DJNZ jumps when B is still nonzero after the decrement
    assign bNonZero = (regB != 8'd1);

    // Write-back, EX AF wins over everything ----------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regB  <= resetMain.b;
            regC  <= resetMain.c;
            regD  <= resetMain.d;
            regE  <= resetMain.e;
            regH  <= resetMain.h;
            regL  <= resetMain.l;
            regA  <= resetMain.a;
            regF  <= resetMain.f;
            altA  <= resetAlt.a;
            altF  <= resetAlt.f;
            regSp <= resetSp;
        end else if (exAf) begin
            regA <= altA;
            altA <= regA;
            regF <= altF;
            altF <= regF;
        end else if (decB) begin
            regB <= regB - 8'd1;
        end else if (writePair) begin
            case (pairSel)
                selBc:   {regB, regC} <= loadWord;
                selDe:   {regD, regE} <= loadWord;
                selHl:   {regH, regL} <= loadWord;
                default: regSp        <= loadWord;
            endcase
        end else if (writeByte) begin
            // Absolute load fills L then H
            case (pairSel)
                byteL:   regL <= dataIn;
                byteH:   regH <= dataIn;
                default: regA <= dataIn;
            endcase
        end
    end

    // Decode raises at most one write kind per cycle
    oneWriteKind: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({writeByte, writePair, exAf, decB}))
        else $error("more than one register write strobe");

endmodule

// ==== hdl/z80Core.sv ====
// Top level of the Z80 subset core
// Decode, execute and register file on two combinational memory ports
`timescale 1ns/1ns

module z80Core (
    input  logic            clk,
    input  logic            rstN,
    output z80RegPkg::addrT codeAddr,
    input  z80RegPkg::byteT codeData,
    output z80RegPkg::addrT dataAddr,
    input  z80RegPkg::byteT dataIn,
    output z80RegPkg::byteT dataOut,
    output logic            dataWrite
);

    import z80IsaPkg::*;
    import z80RegPkg::*;

    // Decode strobes
    logic [1:0] pcStep;
    logic       pcRel;
    tempOpT     tempOp;
    addrSrcT    addrSrc;
    logic       memWrite;
    logic       writeByte;
    logic       writePair;
    pairSelT    pairSel;
    logic       exAf;
    logic       decB;

    // Register read-out
    byteT regA;
    byteT regH;
    byteT regL;
    byteT flags;
    addrT pairBc;
    addrT pairDe;
    logic bNonZero;
    addrT loadWord;

    z80Decode i_decode (
        .clk       (clk),
        .rstN      (rstN),
        .codeData  (codeData),
        .flags     (flags),
        .pcStep    (pcStep),
        .pcRel     (pcRel),
        .tempOp    (tempOp),
        .addrSrc   (addrSrc),
        .memWrite  (memWrite),
        .writeByte (writeByte),
        .writePair (writePair),
        .pairSel   (pairSel),
        .exAf      (exAf),
        .decB      (decB),
        .bNonZero  (bNonZero)
    );

    z80Execute i_execute (
        .clk       (clk),
        .rstN      (rstN),
        .pcStep    (pcStep),
        .pcRel     (pcRel),
        .tempOp    (tempOp),
        .addrSrc   (addrSrc),
        .memWrite  (memWrite),
        .pairSel   (pairSel),
        .codeData  (codeData),
        .dataIn    (dataIn),
        .regA      (regA),
        .regH      (regH),
        .regL      (regL),
        .pairBc    (pairBc),
        .pairDe    (pairDe),
        .codeAddr  (codeAddr),
        .dataAddr  (dataAddr),
        .dataOut   (dataOut),
        .dataWrite (dataWrite),
        .loadWord  (loadWord)
    );

    z80Result i_result (
        .clk       (clk),
        .rstN      (rstN),
        .writeByte (writeByte),
        .writePair (writePair),
        .exAf      (exAf),
        .decB      (decB),
        .pairSel   (pairSel),
        .loadWord  (loadWord),
        .dataIn    (dataIn),
        .regA      (regA),
        .regH      (regH),
        .regL      (regL),
        .flags     (flags),
        .pairBc    (pairBc),
        .pairDe    (pairDe),
        .bNonZero  (bNonZero)
    );

endmodule

// ==== test/z80CoreTb.sv ====
// Testbench for the Z80 subset core
// Shared 64 KB code and data memory with combinational reads
// Clock, reset and golden file loader
// Write checker, halt detection and closing report
`timescale 1ns/1ns

module z80CoreTb;

    import z80RegPkg::*;

    localparam int writeTimeout = 40;
    localparam int haltTimeout  = 40;

    logic clk;
    logic rstN;
    addrT codeAddr;
    byteT codeData;
    addrT dataAddr;
    byteT dataIn;
    byteT dataOut;
    logic dataWrite;

    // One memory behind both ports
    byteT mem [0:65535];
    // Header, program image, expected writes
    logic [15:0] golden [0:255];

    // Bus state captured once inputs have settled
    logic wrSeen;
    addrT wrAddr;
    byteT wrData;
    addrT cyclePc;

    int testCount;
    int checksRun;
    int errorCount;
    int writeCount;

    z80Core i_z80Core (
        .clk       (clk),
        .rstN      (rstN),
        .codeAddr  (codeAddr),
        .codeData  (codeData),
        .dataAddr  (dataAddr),
        .dataIn    (dataIn),
        .dataOut   (dataOut),
        .dataWrite (dataWrite)
    );

    always #10 clk = ~clk;

    // One clock of memory service ------------------
    task automatic stepCycle(input logic rstLevel);
        @(negedge clk);
        rstN     = rstLevel;
        codeData = mem[codeAddr];
        // Data address can follow the code byte
        #1;
        dataIn = mem[dataAddr];
        #1;
        wrSeen  = dataWrite;
        wrAddr  = dataAddr;
        wrData  = dataOut;
        cyclePc = codeAddr;
        @(posedge clk);
        if (wrSeen === 1'b1 && rstLevel) begin
            mem[wrAddr] = wrData;
            writeCount++;
        end
    endtask

    task automatic waitWrite(output logic seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < writeTimeout) begin
            stepCycle(1'b1);
            seen = (wrSeen === 1'b1);
            cycles++;
        end
    endtask

    // Program ends in a JR to itself
    task automatic waitHalt(input addrT haltAddr, output logic reached);
        int cycles;
        cycles  = 0;
        reached = 1'b0;
        while (!reached && cycles < haltTimeout) begin
            stepCycle(1'b1);
            if (wrSeen === 1'b1) begin
                $display("extra write to [%h]=%h at %0t, not in the golden list",
                         wrAddr, wrData, $time);
            end
            reached = (cyclePc === haltAddr);
            cycles++;
        end
    endtask

    // Result checks -------------------------------
    task automatic checkWrite(input int idx, input addrT expAddr, input byteT expData,
                              input addrT gotAddr, input byteT gotData);
        checksRun++;
        if (gotAddr !== expAddr || gotData !== expData) begin
            errorCount++;
            $display("MISMATCH at %0t: write %0d expected [%h]=%h, got [%h]=%h",
                     $time, idx, expAddr, expData, gotAddr, gotData);
        end else begin
            $display("write %0d ok: [%h]=%h", idx, gotAddr, gotData);
        end
    endtask

    task automatic checkCount(input int expCount, input int gotCount);
        checksRun++;
        if (gotCount != expCount) begin
            errorCount++;
            $display("MISMATCH at %0t: write count expected %0d, got %0d",
                     $time, expCount, gotCount);
        end else begin
            $display("write count ok: %0d", gotCount);
        end
    endtask

    // Main sequence -------------------------------
    initial begin
        logic [7:0] gIdx;
        int         imageLen;
        int         expWrites;
        addrT       haltAddr;
        addrT       expAddr;
        byteT       expData;
        logic       seen;
        logic       stopped;
        logic       reached;
        logic       resetClean;

        clk        = 1'b0;
        rstN       = 1'b0;
        codeData   = '0;
        dataIn     = '0;
        wrSeen     = 1'b0;
        wrAddr     = '0;
        wrData     = '0;
        cyclePc    = '0;
        testCount  = 0;
        checksRun  = 0;
        errorCount = 0;
        writeCount = 0;

        // Fill from the full address, image on top
        for (int i = 0; i < 65536; i++) begin
            mem[addrT'(i)] = byteT'(i) ^ byteT'(i >> 8) ^ 8'h5A;
        end
        $readmemh("test/z80Golden.txt", golden);
        imageLen = int'(golden[0]);
        haltAddr = golden[1];
        gIdx     = 8'd2;
        for (int k = 0; k < imageLen; k++) begin
            mem[addrT'(k)] = golden[gIdx][7:0];
            gIdx = gIdx + 8'd1;
        end
        expWrites = int'(golden[gIdx]);
        gIdx = gIdx + 8'd1;
        if (imageLen == 0 || expWrites == 0) begin
            errorCount++;
            $display("golden file is missing or holds no program or writes");
        end

        // Reset, strobe must stay low throughout
        resetClean = 1'b1;
        repeat (8) begin
            stepCycle(1'b0);
            if (wrSeen === 1'b1) begin
                resetClean = 1'b0;
            end
        end
        testCount++;
        checksRun++;
        if (resetClean) begin
            $display("reset ok: no write strobe during reset");
        end else begin
            errorCount++;
            $display("reset failed: write strobe went high during reset");
        end

        // Expected writes in program order
        stopped = 1'b0;
        for (int w = 1; w <= expWrites && !stopped; w++) begin
            expAddr = golden[gIdx];
            expData = golden[gIdx + 8'd1][7:0];
            gIdx = gIdx + 8'd2;
            waitWrite(seen);
            testCount++;
            if (seen) begin
                checkWrite(w, expAddr, expData, wrAddr, wrData);
            end else begin
                errorCount++;
                checksRun++;
                $display("write %0d: expected write did not occur within %0d cycles",
                         w, writeTimeout);
                stopped = 1'b1;
            end
        end

        // Run to the halt loop, then compare totals
        if (!stopped) begin
            waitHalt(haltAddr, reached);
            testCount++;
            if (!reached) begin
                errorCount++;
                $display("program did not reach the halt loop at %h", haltAddr);
            end
            checkCount(expWrites, writeCount);
        end

        $display("tests %0d, checks %0d, errors %0d", testCount, checksRun, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== test/z80Golden.txt ====
// Words for $readmemh: image length, halt address, image bytes from address 0,
// then the write count and address/data pairs in the order the core writes them
0041 003C
// LD HL,1234h / LD (8000h),HL
21 34 12 22 00 80
// LD BC,8010h / LD DE,8020h / LD (BC),A / LD (DE),A / two unknown opcodes
01 10 80 11 20 80 02 12 3C 47
// LD DE,003Eh / LD A,(DE) / LD (BC),A / LD HL,(003Fh) / LD (80FFh),HL
11 3E 00 1A 02 2A 3F 00 22 FF 80
// JR NZ and JR NC over stores, EX AF,AF', LD (BC),A, JR Z and JR C over stores
20 01 02 30 01 12 08 02 28 01 02 38 01 12
// LD DE,8050h / LD BC,0300h / LD (DE),A looped by DJNZ
11 50 80 01 00 03 12 10 FD
// JR over dead stores, unknown opcode, LD BC,8060h / LD (BC),A / JR to itself
18 03 02 12 02 AF 01 60 80 02 18 FE
// Data byte for LD A,(DE), data word for LD HL,(nn)
A5 C3 7E
// Expected writes
000C
8000 34
8001 12
8010 00
8020 00
8010 A5
80FF C3
8100 7E
8010 FA
8050 FA
8050 FA
8050 FA
8060 FA

// ==== z80Core.f ====
hdl/z80IsaPkg.sv
hdl/z80RegPkg.sv
hdl/z80Decode.sv
hdl/z80Execute.sv
hdl/z80Result.sv
hdl/z80Core.sv
test/z80CoreTb.sv

// ==== Makefile ====
# Verilator build, run and lint for the Z80 subset core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f z80Core.f --top-module z80CoreTb \
		-Mdir obj_dir -o z80CoreTb

run: build
	@./obj_dir/z80CoreTb > sim.log 2>&1; status=$$?; cat sim.log; \
		if [ $$status -ne 0 ] || grep -q "Checks failed" sim.log; then \
			echo "simulation failed"; exit 1; fi

lint:
	verilator --lint-only --timing --assert -f z80Core.f --top-module z80CoreTb

clean:
	rm -rf obj_dir sim.log
